/* verilog/sfmPkg.sv */
`default_nettype none
// --------------------------------------------------------------------
// Shared types and widths for the serial-flash read side.
// Imported by the engine, the register block and the flash model.
// --------------------------------------------------------------------
package sfmPkg;

	// --------------------------------------------------------------------
	// Engine FSM states
	// --------------------------------------------------------------------
	typedef enum logic [2:0] {
		eSfmIdle,
		// Opcode going out on MOSI
		eSfmCmd,
		// 24 address bits
		eSfmAdrs,
		// Page bytes coming back
		eSfmData,
		// Single byte exchange for the CPU
		eSfmCpuByte,
		// Chip select held high before the next access
		eSfmCsHold
	} SfmStateE;

	// Flash opcodes, only the plain read is ever issued
	typedef enum logic [7:0] {
		eOpRead = 8'h03
	} SfmOpcodeE;

	// --------------------------------------------------------------------
	// Widths
	// --------------------------------------------------------------------
	// Byte address bits inside one page, 256-byte pages
	localparam int cSfmPageBits = 8;

	// Full flash byte address
	localparam int cSfmAdrsBits = 24;

	// Bus address bit that marks a write cycle
	localparam int cUsiWriteBit = 30;

endpackage

`default_nettype wire

/* verilog/audioTxCsr.sv */
`default_nettype none
// --------------------------------------------------------------------
// Register block for the flash channels. Decodes bus writes, holds the
// channel settings and returns the selected register one edge later.
// --------------------------------------------------------------------
module audioTxCsr #(
	parameter int pSfmNum = 3,
	parameter int pSfmPageWidth = 16,
	parameter logic [7:0] pAdrsMap = 8'h04,
	parameter int pUsiBusWidth = 32
)(
	input wire iSCLK,
	input wire iSRST,
	// Register bus
	input wire [pUsiBusWidth-1:0] iSUsiAdrs,
	input wire [pUsiBusWidth-1:0] iSUsiWd,
	output logic [pUsiBusWidth-1:0] oSUsiRd,
	// Channel settings
	output logic [pSfmNum-1:0] oSfmIoHiz,
	output logic [pSfmNum-1:0] oSfmEn,
	output logic [pSfmNum-1:0] oSfmCycleEn,
	output logic [pSfmNum*8-1:0] oSfmDiv,
	output logic [pSfmNum*8-1:0] oSfmCsHoldTime,
	output logic [pSfmNum*pSfmPageWidth-1:0] oSfmStartAdrs,
	output logic [pSfmNum*pSfmPageWidth-1:0] oSfmEndAdrs,
	output logic [pSfmNum*8-1:0] oSfmCpuWd,
	output logic [pSfmNum-1:0] oSfmCpuEn,
	output logic [pSfmNum-1:0] oSfmCpuCsCtrl,
	output logic [pSfmNum-1:0] oSfmCpuValid,
	// Engine events
	input wire [pSfmNum-1:0] iSfmDone,
	input wire [pSfmNum-1:0] iSfmCpuDone,
	input wire [pSfmNum*8-1:0] iSfmCpuRd
);
	import sfmPkg::*;

	logic wrHit;
	logic [7:0] csrOfs;
	logic [pSfmNum-1:0] rDone;
	logic [pSfmNum*8-1:0] rCpuRd;
	logic [pUsiBusWidth-1:0] rdNext;

	// Block select plus write strobe in the address word
	assign csrOfs = iSUsiAdrs[7:0];
	assign wrHit = iSUsiAdrs[cUsiWriteBit] && (iSUsiAdrs[23:16] == pAdrsMap);

	function automatic logic wrAt(input logic [7:0] ofs);
		return wrHit && (csrOfs == ofs);
	endfunction

	// --------------------------------------------------------------------
	// Register writes and engine updates
	// --------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			oSfmIoHiz <= '0;
			oSfmEn <= '0;
			oSfmCycleEn <= '0;
			oSfmDiv <= '0;
			oSfmCsHoldTime <= '0;
			oSfmStartAdrs <= '0;
			oSfmEndAdrs <= '0;
			oSfmCpuWd <= '0;
			oSfmCpuEn <= '0;
			oSfmCpuCsCtrl <= '0;
			oSfmCpuValid <= '0;
			rDone <= '0;
			rCpuRd <= '0;
		end
		else
		begin
			if (wrAt(8'h00))
				oSfmIoHiz <= iSUsiWd[pSfmNum-1:0];
			if (wrAt(8'h08))
				oSfmCycleEn <= iSUsiWd[pSfmNum-1:0];
			if (wrAt(8'h0C))
				oSfmDiv <= iSUsiWd[pSfmNum*8-1:0];
			if (wrAt(8'h10))
				oSfmCsHoldTime <= iSUsiWd[pSfmNum*8-1:0];
			if (wrAt(8'h14))
				oSfmCpuWd <= iSUsiWd[pSfmNum*8-1:0];
			if (wrAt(8'h1C))
				oSfmCpuCsCtrl <= iSUsiWd[pSfmNum-1:0];
			if (wrAt(8'h20))
				oSfmCpuValid <= iSUsiWd[pSfmNum-1:0];

			for (int i = 0; i < pSfmNum; i++)
			begin
				// Engine events win over a bus write in the same cycle
				if (iSfmDone[i])
					oSfmEn[i] <= oSfmCycleEn[i];
				else if (wrAt(8'h04))
					oSfmEn[i] <= iSUsiWd[i];

				if (iSfmCpuDone[i])
				begin
					oSfmCpuEn[i] <= 1'b0;
					rDone[i] <= 1'b1;
					rCpuRd[i*8 +: 8] <= iSfmCpuRd[i*8 +: 8];
				end
				else
				begin
					if (wrAt(8'h18))
						oSfmCpuEn[i] <= iSUsiWd[i];
					// Any write to Done clears it
					if (wrAt(8'h30))
						rDone[i] <= 1'b0;
				end

				// Page pairs sit 8 bytes apart per channel
				if (wrAt(8'(8'h60 + 8 * i)))
					oSfmStartAdrs[i*pSfmPageWidth +: pSfmPageWidth] <= iSUsiWd[pSfmPageWidth-1:0];
				if (wrAt(8'(8'h64 + 8 * i)))
					oSfmEndAdrs[i*pSfmPageWidth +: pSfmPageWidth] <= iSUsiWd[pSfmPageWidth-1:0];
			end
		end
	end

	// --------------------------------------------------------------------
	// Read-back mux, zero filled
	// --------------------------------------------------------------------
	always_comb
	begin
		rdNext = '0;
		case (csrOfs)
			8'h00: rdNext[pSfmNum-1:0] = oSfmIoHiz;
			8'h04: rdNext[pSfmNum-1:0] = oSfmEn;
			8'h08: rdNext[pSfmNum-1:0] = oSfmCycleEn;
			8'h0C: rdNext[pSfmNum*8-1:0] = oSfmDiv;
			8'h10: rdNext[pSfmNum*8-1:0] = oSfmCsHoldTime;
			8'h14: rdNext[pSfmNum*8-1:0] = oSfmCpuWd;
			8'h18: rdNext[pSfmNum-1:0] = oSfmCpuEn;
			8'h1C: rdNext[pSfmNum-1:0] = oSfmCpuCsCtrl;
			8'h20: rdNext[pSfmNum-1:0] = oSfmCpuValid;
			8'h30: rdNext[pSfmNum-1:0] = rDone;
			// Unmapped offsets echo the write data
			default: rdNext = iSUsiWd;
		endcase
		for (int i = 0; i < pSfmNum; i++)
		begin
			if (csrOfs == 8'(8'h60 + 8 * i))
			begin
				rdNext = '0;
				rdNext[pSfmPageWidth-1:0] = oSfmStartAdrs[i*pSfmPageWidth +: pSfmPageWidth];
			end
			if (csrOfs == 8'(8'h64 + 8 * i))
			begin
				rdNext = '0;
				rdNext[pSfmPageWidth-1:0] = oSfmEndAdrs[i*pSfmPageWidth +: pSfmPageWidth];
			end
			if (csrOfs == 8'(8'h90 + 4 * i))
			begin
				rdNext = '0;
				rdNext[7:0] = rCpuRd[i*8 +: 8];
			end
		end
	end

	always_ff @(posedge iSCLK)
	begin
		oSUsiRd <= rdNext;
	end

	// A finished CPU byte must not be started again by a stale CpuEn
	assert property (@(posedge iSCLK) disable iff (iSRST)
		|iSfmCpuDone |=> ((oSfmCpuEn & $past(iSfmCpuDone)) == '0));

endmodule

`default_nettype wire

/* verilog/sfmSpiEngine.sv */
`default_nettype none
// --------------------------------------------------------------------
// One serial flash channel. Streams whole pages with the read opcode
// or exchanges single bytes for the CPU; one instance per channel.
// --------------------------------------------------------------------
module sfmSpiEngine #(
	parameter int pSfmPageWidth = 16
)(
	input wire iSCLK,
	input wire iSRST,
	// Settings from the register block
	input wire iIoHiz,
	input wire iEn,
	input wire iCycleEn,
	input wire [7:0] iDiv,
	input wire [7:0] iCsHoldTime,
	input wire [pSfmPageWidth-1:0] iStartAdrs,
	input wire [pSfmPageWidth-1:0] iEndAdrs,
	input wire [7:0] iCpuWd,
	input wire iCpuEn,
	input wire iCpuCsCtrl,
	input wire iCpuValid,
	// Events back to the register block
	output logic oDone,
	output logic oCpuDone,
	output logic [7:0] oCpuRd,
	// Flash pins
	output logic oSck,
	output logic oCs,
	output logic oMosi,
	input wire iMiso,
	output logic oOe,
	// Audio byte stream
	output logic [7:0] oAudioData,
	output logic oAudioValid
);
	import sfmPkg::*;

	localparam int cTxBits = 8 + cSfmAdrsBits;

	SfmStateE state;
	logic [7:0] divCnt;
	logic [4:0] bitCnt;
	logic [7:0] holdCnt;
	logic enPrev;
	logic streamMode;
	logic cycleRun;
	logic cpuRun;
	logic [cTxBits-1:0] txShift;
	logic [7:0] rxShift;
	logic [pSfmPageWidth-1:0] curPage;
	logic [cSfmPageBits-1:0] byteCnt;
	logic [cSfmAdrsBits-1:0] startAdrs;
	logic shifting;
	logic tick;
	logic riseTick;
	logic fallTick;
	logic bitLast;
	logic byteEnd;
	logic lastByte;
	logic holdDone;
	logic cpuReq;
	logic loadStream;
	logic loadCpu;

	// Page number followed by a zero byte column
	assign startAdrs = cSfmAdrsBits'({iStartAdrs, {cSfmPageBits{1'b0}}});

	assign shifting = (state == eSfmCmd) || (state == eSfmAdrs) || (state == eSfmData)
		|| ((state == eSfmCpuByte) && cpuRun);
	// Half serial clock period is Div+1 cycles
	assign tick = shifting && (divCnt == iDiv);
	assign riseTick = tick && !oSck;
	assign fallTick = tick && oSck;
	assign bitLast = (state == eSfmAdrs) ? (bitCnt == 5'(cSfmAdrsBits - 1)) : (bitCnt == 5'd7);
	assign byteEnd = fallTick && bitLast;
	assign lastByte = (byteCnt == {cSfmPageBits{1'b1}}) && (curPage == iEndAdrs);
	assign holdDone = (state == eSfmCsHold) && (holdCnt == iCsHoldTime);

	assign cpuReq = iCpuEn && iCpuValid && !oCpuDone;
	// Restart uses the cycle setting seen when the last page byte arrived
	assign loadStream = ((state == eSfmIdle) && iEn && !enPrev)
		|| (holdDone && streamMode && cycleRun && iEn);
	assign loadCpu = cpuReq && (((state == eSfmIdle) && !loadStream)
		|| ((state == eSfmCpuByte) && !cpuRun));

	assign oMosi = txShift[cTxBits-1];
	assign oOe = ~iIoHiz;

	// --------------------------------------------------------------------
	// FSM and pin control
	// --------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state <= eSfmIdle;
			divCnt <= '0;
			bitCnt <= '0;
			holdCnt <= '0;
			enPrev <= 1'b0;
			streamMode <= 1'b0;
			cycleRun <= 1'b0;
			cpuRun <= 1'b0;
			oSck <= 1'b0;
			oCs <= 1'b1;
			oAudioValid <= 1'b0;
			oDone <= 1'b0;
			oCpuDone <= 1'b0;
		end
		else
		begin
			enPrev <= iEn;
			oAudioValid <= 1'b0;
			oDone <= 1'b0;
			oCpuDone <= 1'b0;
			divCnt <= (tick || !shifting) ? 8'd0 : divCnt + 8'd1;

			if (riseTick)
				oSck <= 1'b1;
			if (fallTick)
			begin
				oSck <= 1'b0;
				bitCnt <= bitLast ? 5'd0 : bitCnt + 5'd1;
			end

			case (state)
				eSfmIdle:
				begin
					if (loadStream)
					begin
						streamMode <= 1'b1;
						oCs <= 1'b0;
						bitCnt <= '0;
						state <= eSfmCmd;
					end
					else if (loadCpu)
					begin
						streamMode <= 1'b0;
						cpuRun <= 1'b1;
						oCs <= 1'b0;
						bitCnt <= '0;
						state <= eSfmCpuByte;
					end
				end
				eSfmCmd:
				begin
					if (byteEnd)
						state <= eSfmAdrs;
				end
				eSfmAdrs:
				begin
					if (byteEnd)
						state <= eSfmData;
				end
				eSfmData:
				begin
					if (byteEnd)
					begin
						oAudioValid <= 1'b1;
						if (lastByte)
						begin
							oCs <= 1'b1;
							holdCnt <= '0;
							cycleRun <= iCycleEn;
							state <= eSfmCsHold;
						end
					end
				end
				eSfmCpuByte:
				begin
					if (cpuRun && byteEnd)
					begin
						cpuRun <= 1'b0;
						oCpuDone <= 1'b1;
						// CS stays low between bytes while CsCtrl is set
						if (!iCpuCsCtrl)
						begin
							oCs <= 1'b1;
							holdCnt <= '0;
							state <= eSfmCsHold;
						end
					end
					else if (loadCpu)
					begin
						cpuRun <= 1'b1;
						bitCnt <= '0;
					end
					else if (!cpuRun && !iCpuCsCtrl)
					begin
						oCs <= 1'b1;
						holdCnt <= '0;
						state <= eSfmCsHold;
					end
				end
				eSfmCsHold:
				begin
					holdCnt <= holdCnt + 8'd1;
					if (holdDone)
					begin
						oDone <= streamMode;
						if (loadStream)
						begin
							oCs <= 1'b0;
							bitCnt <= '0;
							state <= eSfmCmd;
						end
						else
							state <= eSfmIdle;
					end
				end
				default:
					state <= eSfmIdle;
			endcase
		end
	end

	// --------------------------------------------------------------------
	// Shift registers and page position
	// --------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (loadStream)
		begin
			txShift <= {eOpRead, startAdrs};
			curPage <= iStartAdrs;
			byteCnt <= '0;
		end
		else if (loadCpu)
			txShift <= {iCpuWd, {cSfmAdrsBits{1'b0}}};
		else if (fallTick)
			txShift <= txShift << 1;

		// MSB first on both lines
		if (riseTick)
			rxShift <= {rxShift[6:0], iMiso};

		if (byteEnd && (state == eSfmData))
		begin
			oAudioData <= rxShift;
			byteCnt <= byteCnt + 1'b1;
			if (byteCnt == {cSfmPageBits{1'b1}})
				curPage <= curPage + 1'b1;
		end
		if (byteEnd && (state == eSfmCpuByte))
			oCpuRd <= rxShift;
	end

	assert property (@(posedge iSCLK) disable iff (iSRST) (state == eSfmIdle) |-> oCs);

	// The pulse is registered, so it trails the data state by one edge
	assert property (@(posedge iSCLK) disable iff (iSRST)
		oAudioValid |-> ($past(state) == eSfmData));

endmodule

`default_nettype wire

/* verilog/audioTxSfm.sv */
`default_nettype none
// --------------------------------------------------------------------
// Flash read side of the audio transmitter. Register block plus one
// engine per flash channel.
// --------------------------------------------------------------------
module audioTxSfm #(
	parameter int pSfmNum = 3,
	parameter int pSfmPageWidth = 16,
	parameter logic [7:0] pAdrsMap = 8'h04,
	parameter int pUsiBusWidth = 32
)(
	input wire iSCLK,
	input wire iSRST,
	input wire [pUsiBusWidth-1:0] iSUsiAdrs,
	input wire [pUsiBusWidth-1:0] iSUsiWd,
	output wire [pUsiBusWidth-1:0] oSUsiRd,
	output wire [pSfmNum-1:0] oSfmSck,
	output wire [pSfmNum-1:0] oSfmCs,
	output wire [pSfmNum-1:0] oSfmMosi,
	input wire [pSfmNum-1:0] iSfmMiso,
	output wire [pSfmNum-1:0] oSfmOe,
	output wire [pSfmNum*8-1:0] oAudioData,
	output wire [pSfmNum-1:0] oAudioValid
);
	wire [pSfmNum-1:0] ioHiz;
	wire [pSfmNum-1:0] en;
	wire [pSfmNum-1:0] cycleEn;
	wire [pSfmNum*8-1:0] div;
	wire [pSfmNum*8-1:0] csHoldTime;
	wire [pSfmNum*pSfmPageWidth-1:0] startAdrs;
	wire [pSfmNum*pSfmPageWidth-1:0] endAdrs;
	wire [pSfmNum*8-1:0] cpuWd;
	wire [pSfmNum-1:0] cpuEn;
	wire [pSfmNum-1:0] cpuCsCtrl;
	wire [pSfmNum-1:0] cpuValid;
	wire [pSfmNum-1:0] sfmDone;
	wire [pSfmNum-1:0] sfmCpuDone;
	wire [pSfmNum*8-1:0] sfmCpuRd;

	audioTxCsr #(
		.pSfmNum(pSfmNum),
		.pSfmPageWidth(pSfmPageWidth),
		.pAdrsMap(pAdrsMap),
		.pUsiBusWidth(pUsiBusWidth)
	) i_audioTxCsr (
		.iSCLK(iSCLK), .iSRST(iSRST),
		.iSUsiAdrs(iSUsiAdrs), .iSUsiWd(iSUsiWd), .oSUsiRd(oSUsiRd),
		.oSfmIoHiz(ioHiz), .oSfmEn(en), .oSfmCycleEn(cycleEn),
		.oSfmDiv(div), .oSfmCsHoldTime(csHoldTime),
		.oSfmStartAdrs(startAdrs), .oSfmEndAdrs(endAdrs),
		.oSfmCpuWd(cpuWd), .oSfmCpuEn(cpuEn),
		.oSfmCpuCsCtrl(cpuCsCtrl), .oSfmCpuValid(cpuValid),
		.iSfmDone(sfmDone), .iSfmCpuDone(sfmCpuDone), .iSfmCpuRd(sfmCpuRd)
	);

	// One engine per channel on its slice of the settings
	for (genvar ch = 0; ch < pSfmNum; ch++)
	begin : gSfm
		sfmSpiEngine #(
			.pSfmPageWidth(pSfmPageWidth)
		) i_sfmSpiEngine (
			.iSCLK(iSCLK), .iSRST(iSRST),
			.iIoHiz(ioHiz[ch]), .iEn(en[ch]), .iCycleEn(cycleEn[ch]),
			.iDiv(div[ch*8 +: 8]), .iCsHoldTime(csHoldTime[ch*8 +: 8]),
			.iStartAdrs(startAdrs[ch*pSfmPageWidth +: pSfmPageWidth]),
			.iEndAdrs(endAdrs[ch*pSfmPageWidth +: pSfmPageWidth]),
			.iCpuWd(cpuWd[ch*8 +: 8]), .iCpuEn(cpuEn[ch]),
			.iCpuCsCtrl(cpuCsCtrl[ch]), .iCpuValid(cpuValid[ch]),
			.oDone(sfmDone[ch]), .oCpuDone(sfmCpuDone[ch]), .oCpuRd(sfmCpuRd[ch*8 +: 8]),
			.oSck(oSfmSck[ch]), .oCs(oSfmCs[ch]), .oMosi(oSfmMosi[ch]),
			.iMiso(iSfmMiso[ch]), .oOe(oSfmOe[ch]),
			.oAudioData(oAudioData[ch*8 +: 8]), .oAudioValid(oAudioValid[ch])
		);
	end

endmodule

`default_nettype wire

/* tests/sfmFlashModel.sv */
`default_nettype none
// --------------------------------------------------------------------
// Read-only serial flash for simulation. Answers the read opcode with
// low address byte ^ middle address byte ^ channel number.
// --------------------------------------------------------------------
module sfmFlashModel #(
	parameter logic [7:0] pChan = 8'd0
)(
	input wire iSck,
	input wire iCs,
	input wire iMosi,
	output logic oMiso
);
	import sfmPkg::*;

	int bitCnt = 0;
	logic [31:0] cmdShift = '0;

	function automatic logic [7:0] dataAt(input logic [23:0] adrs);
		return adrs[7:0] ^ adrs[15:8] ^ pChan;
	endfunction

	initial oMiso = 1'b0;

	// New command on every chip select fall
	always @(negedge iCs)
	begin
		bitCnt = 0;
		cmdShift = '0;
		oMiso = 1'b0;
	end

	// Opcode and address sampled on the rising edge
	always @(posedge iSck)
	begin
		if (!iCs)
		begin
			if (bitCnt < 32)
				cmdShift = {cmdShift[30:0], iMosi};
			bitCnt = bitCnt + 1;
		end
	end

	// Data driven on the falling edge, MSB first
	always @(negedge iSck)
	begin
		logic [23:0] adrs;
		logic [7:0] value;
		int dataBit;
		if (!iCs && (bitCnt >= 32) && (cmdShift[31:24] == eOpRead))
		begin
			dataBit = bitCnt - 32;
			adrs = cmdShift[23:0] + 24'(dataBit / 8);
			value = dataAt(adrs);
			oMiso = value[7 - (dataBit % 8)];
		end
		else
			oMiso = 1'b0;
	end

endmodule

`default_nettype wire

/* tests/tbAudioTxSfm.sv */
`default_nettype none
// --------------------------------------------------------------------
// Testbench for the flash read side. Runs the operations listed in the
// pattern file against the DUT and three flash models.
// --------------------------------------------------------------------
module tbAudioTxSfm;
	import sfmPkg::*;

	localparam int cNum = 3;
	localparam logic [7:0] cAdrsMap = 8'h04;
	// System cycles per serial bit with Div = 1
	localparam int cBitCycles = 4;
	localparam int cPollMax = 20000;
	localparam int cByteWait = 2000;
	// Four words per operation
	localparam int cPatWords = 1024;

	logic iSCLK = 1'b0;
	logic iSRST = 1'b1;
	logic [31:0] iSUsiAdrs = '0;
	logic [31:0] iSUsiWd = '0;
	wire [31:0] oSUsiRd;
	wire [cNum-1:0] oSfmSck;
	wire [cNum-1:0] oSfmCs;
	wire [cNum-1:0] oSfmMosi;
	wire [cNum-1:0] iSfmMiso;
	wire [cNum-1:0] oSfmOe;
	wire [cNum*8-1:0] oAudioData;
	wire [cNum-1:0] oAudioValid;

	logic [31:0] pattern [0:cPatWords-1];
	logic [31:0] lfsr = 32'hec8b1f6a;
	logic loaded = 1'b0;
	int streamCnt = 0;
	int errCnt = 0;
	int testCnt = 0;
	int failCnt = 0;

	audioTxSfm #(
		.pSfmNum(cNum),
		.pSfmPageWidth(16),
		.pAdrsMap(cAdrsMap),
		.pUsiBusWidth(32)
	) i_audioTxSfm (
		.iSCLK(iSCLK), .iSRST(iSRST),
		.iSUsiAdrs(iSUsiAdrs), .iSUsiWd(iSUsiWd), .oSUsiRd(oSUsiRd),
		.oSfmSck(oSfmSck), .oSfmCs(oSfmCs), .oSfmMosi(oSfmMosi),
		.iSfmMiso(iSfmMiso), .oSfmOe(oSfmOe),
		.oAudioData(oAudioData), .oAudioValid(oAudioValid)
	);

	for (genvar ch = 0; ch < cNum; ch++)
	begin : gFlash
		sfmFlashModel #(
			.pChan(8'(ch))
		) i_sfmFlashModel (
			.iSck(oSfmSck[ch]), .iCs(oSfmCs[ch]),
			.iMosi(oSfmMosi[ch]), .oMiso(iSfmMiso[ch])
		);
	end

	always #20 iSCLK = ~iSCLK;

	// --------------------------------------------------------------------
	// Helpers
	// --------------------------------------------------------------------
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// Reference byte of flash n at byte address A
	function automatic logic [7:0] flashByte(input int ch, input logic [23:0] adrs);
		return adrs[7:0] ^ adrs[15:8] ^ 8'(ch);
	endfunction

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("error t=%0t %s got %h expected %h", $time, name, got, exp);
			errCnt++;
		end
	endtask

	task automatic randomByte(output logic [7:0] value);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsrStep(lfsr);
			value = {value[6:0], lfsr[0]};
		end
	endtask

	task automatic busWrite(input logic [7:0] ofs, input logic [31:0] data);
		@(posedge iSCLK);
		iSUsiAdrs <= (32'd1 << cUsiWriteBit) | {8'h00, cAdrsMap, 8'h00, ofs};
		iSUsiWd <= data;
		@(posedge iSCLK);
		iSUsiAdrs <= '0;
		iSUsiWd <= '0;
	endtask

	task automatic busRead(input logic [7:0] ofs, input logic [31:0] data,
		output logic [31:0] value);
		@(posedge iSCLK);
		iSUsiAdrs <= {8'h00, cAdrsMap, 8'h00, ofs};
		iSUsiWd <= data;
		@(posedge iSCLK);
		@(negedge iSCLK);
		value = oSUsiRd;
	endtask

	task automatic pollReg(input logic [7:0] ofs, input logic [31:0] exp);
		logic [31:0] value;
		int n;
		n = 0;
		value = '0;
		while (n < cPollMax)
		begin
			busRead(ofs, '0, value);
			if (value == exp)
				break;
			n++;
		end
		if (value != exp)
		begin
			$display("register %h never reached %h, last value %h", ofs, exp, value);
			errCnt++;
		end
	endtask

	// Collect one page stream and compare with the flash rule
	task automatic checkStream(input int ch, input logic [15:0] page);
		logic [23:0] adrs;
		int waitCnt;
		adrs = {page, {cSfmPageBits{1'b0}}};
		for (int k = 0; k < 256; k++)
		begin
			waitCnt = 0;
			@(negedge iSCLK);
			while (!oAudioValid[ch] && (waitCnt < cByteWait * cBitCycles))
			begin
				@(negedge iSCLK);
				waitCnt++;
			end
			if (!oAudioValid[ch])
			begin
				$display("channel %0d stopped streaming after %0d bytes", ch, k);
				errCnt++;
				return;
			end
			checkEq($sformatf("oAudioData[%0d]", ch), 32'(oAudioData[ch*8 +: 8]),
				32'(flashByte(ch, adrs + 24'(k))));
		end
	endtask

	task automatic cpuByte(input int ch, input logic [7:0] data, input logic useRandom);
		logic [7:0] value;
		value = data;
		if (useRandom)
			randomByte(value);
		busWrite(8'h30, '0);
		busWrite(8'h14, 32'(value) << (8 * ch));
		busWrite(8'h18, 32'd1 << ch);
		pollReg(8'h30, 32'd1 << ch);
	endtask

	// --------------------------------------------------------------------
	// Pattern runner
	// --------------------------------------------------------------------
	initial
	begin
		logic [31:0] value;
		int idx;
		int errBefore;
		$readmemh("tests/audioTxSfmPatterns.txt", pattern);
		for (int i = 0; i < cPatWords; i += 4)
		begin
			if (pattern[i] === 32'd0)
				break;
			if (pattern[i] == 32'd3)
				streamCnt++;
		end
		loaded = 1'b1;

		repeat (3) @(posedge iSCLK);
		iSRST <= 1'b0;

		idx = 0;
		while ((idx < cPatWords) && (pattern[idx] !== 32'd0))
		begin
			errBefore = errCnt;
			case (pattern[idx])
				1: busWrite(pattern[idx+1][7:0], pattern[idx+2]);
				2:
				begin
					busRead(pattern[idx+1][7:0], pattern[idx+2], value);
					checkEq($sformatf("oSUsiRd@%h", pattern[idx+1][7:0]), value, pattern[idx+3]);
				end
				3: checkStream(int'(pattern[idx+1]), pattern[idx+2][15:0]);
				4: cpuByte(int'(pattern[idx+1]), pattern[idx+2][7:0], pattern[idx+3] != 0);
				5: pollReg(pattern[idx+1][7:0], pattern[idx+3]);
				6:
				begin
					@(negedge iSCLK);
					checkEq("oSfmOe", 32'(oSfmOe), pattern[idx+3]);
				end
				default:
				begin
					$display("unknown operation %h in pattern file", pattern[idx]);
					errCnt++;
				end
			endcase
			testCnt++;
			if (errCnt != errBefore)
				failCnt++;
			$display("test %0d op %0d %s", testCnt, pattern[idx],
				(errCnt == errBefore) ? "ok" : "failed");
			idx += 4;
		end

		$display("%0d tests, %0d failed, %0d errors", testCnt, failCnt, errCnt);
		if (errCnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Limit from stream count, bit time and a margin for bus traffic
	initial
	begin
		wait (loaded);
		#(longint'(streamCnt * (32 + 2048) * cBitCycles + 60000) * 40);
		$display("watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/audioTxSfmPatterns.txt */
// op offset data expect; op 1 write, 2 read, 3 stream (offset=ch, data=page),
// 4 cpu byte (offset=ch, expect 1 = random), 5 poll, 6 check oSfmOe, 0 end
2 00 0 0  2 04 0 0  2 0C 0 0  2 30 0 0  2 60 0 0  2 94 0 0
1 00 FFFFFFFD 0  2 00 0 5  6 0 0 2  1 00 0 0  6 0 0 7
1 0C AB010101 0  2 0C 0 010101  1 10 12202020 0  2 10 0 202020
1 14 FFFFFFFF 0  2 14 0 FFFFFF  1 18 F 0  2 18 0 7  1 18 0 0  2 18 0 0
1 1C 6 0  2 1C 0 6  1 1C 0 0  1 20 5 0  2 20 0 5  1 20 0 0
1 60 ABCD0012 0  2 60 0 12  1 64 12 0  2 64 0 12
1 68 105 0  1 6C 105 0  2 6C 0 105  1 70 A3 0  1 74 A3 0  2 74 0 A3
2 40 5A5AA5A5 5A5AA5A5
1 04 1 0  3 0 12 0  5 04 0 0  1 04 2 0  3 1 105 0  5 04 0 0
1 04 4 0  3 2 A3 0  5 04 0 0
1 08 1 0  1 04 1 0  3 0 12 0  1 08 0 0  3 0 12 0  5 04 0 0  2 04 0 0
1 20 2 0  1 1C 2 0  4 1 03 0  4 1 00 0  4 1 12 0  4 1 34 0  4 1 0 1
1 1C 0 0  2 18 0 0  2 30 0 2  1 30 0 0  2 30 0 0  2 94 0 27
0 0 0 0

/* tb.f */
verilog/sfmPkg.sv
verilog/audioTxCsr.sv
verilog/sfmSpiEngine.sv
verilog/audioTxSfm.sv
tests/sfmFlashModel.sv
tests/tbAudioTxSfm.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator from the project root
rm -f sim.log
verilator --binary --assert --timing -Wno-fatal -f tb.f --top-module tbAudioTxSfm -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 || echo "build or run failed"
cat sim.log 2>/dev/null
grep -qx 'STATUS: PASS' sim.log && exit 0 || exit 1
